//--- files.f
source/video_pkg.sv
source/uart_pkg.sv
source/uart_activity_monitor.sv
source/icon_window_locator.sv
source/icon_bitmap_fetch.sv
source/icon_overlay_mixer.sv
source/status_icon_overlay.sv
tb/tb_clock_gen.sv
tb/tb_status_icon_overlay.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f files.f --top-module tb_status_icon_overlay -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "^test passed$" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

//--- tb/tb_status_icon_overlay.sv
`timescale 1ns/1ps

module tb_status_icon_overlay
  import video_pkg::*, uart_pkg::*;
();

  localparam logic [coord_w-1:0] frame_end = 9'd311;
  localparam logic [coord_w-1:0] win_top   = frame_end - icon_y_lead;
  localparam logic [coord_w-1:0] idle_pos  = 9'd10;

  // Column 0 is the leftmost pixel and the MSB of each row
  localparam logic [icon_size-1:0] link_rows [icon_size] = '{
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0FF0, 16'h0000, 16'h07E0, 16'h0000,
    16'h03C0, 16'h0000, 16'h0180, 16'h0180, 16'h0000, 16'h0000, 16'h0000, 16'h0000
  };
  localparam logic [icon_size-1:0] no_link_rows [icon_size] = '{
    16'h07E0, 16'h0810, 16'h300C, 16'h2004, 16'h4FFE, 16'h8032, 16'h87E1, 16'h8181,
    16'h83C1, 16'h8601, 16'h8C01, 16'h5982, 16'h3004, 16'h300C, 16'h0C30, 16'h03C0
  };

  logic               sysclk;
  logic               rst_n;
  logic [coord_w-1:0] hcnt;
  logic [coord_w-1:0] vcnt;
  logic [coord_w-1:0] end_count_v;
  logic [rgb_w-1:0]   rin;
  logic [rgb_w-1:0]   gin;
  logic [rgb_w-1:0]   bin;
  logic [rgb_w-1:0]   r;
  logic [rgb_w-1:0]   g;
  logic [rgb_w-1:0]   b;
  logic               uart_rx;
  logic               uart_tx;
  logic               wifi_enable;
  logic               uart_reset_n;

  // Levels applied together with the next pixel
  logic               rx_level = 1'b1;
  logic               tx_level = 1'b1;
  logic               wifi_level = 1'b1;

  logic [31:0]        lfsr_state = 32'h824f;
  int                 cycle_no = 0;
  logic [3*rgb_w-1:0] exp_q [$];
  bit                 care_q [$];

  tb_clock_gen #(.period(100), .reset_cycles(8)) clock0 (.sysclk(sysclk), .rst_n(rst_n));

  status_icon_overlay #(.hold_cycles(hold_cnt_w'(64))) dut0 (
    .sysclk(sysclk), .rst_n(rst_n), .hcnt(hcnt), .vcnt(vcnt), .end_count_v(end_count_v),
    .rin(rin), .gin(gin), .bin(bin), .uart_rx(uart_rx), .uart_tx(uart_tx),
    .wifi_enable(wifi_enable), .r(r), .g(g), .b(b), .uart_reset_n(uart_reset_n)
  );

  // ------------------------------
  // Checking helpers
  // ------------------------------

  task automatic stop_run();
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_channel(input string name, input logic [rgb_w-1:0] actual,
                                 input logic [rgb_w-1:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
      stop_run();
    end
  endtask

  task automatic compare_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s is %0b, expected %0b", $time, name, actual, expected);
      stop_run();
    end
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  // Set icon pixel at a screen position, zero outside the window
  function automatic logic icon_lit(input logic [coord_w-1:0] hc, input logic [coord_w-1:0] vc,
                                    input logic wifi);
    int                   col;
    int                   row;
    logic [icon_size-1:0] bits;
    col = int'(hc) - int'(icon_x_first);
    row = int'(vc) - int'(win_top);
    if (col < 0 || col >= icon_size || row < 0 || row >= icon_size) begin
      return 1'b0;
    end
    bits = wifi ? link_rows[row] : no_link_rows[row];
    return bits[icon_size - 1 - col];
  endfunction

  // One pixel per clock, checked three cycles later
  // vis 0 icon hidden, 1 icon shown, 2 unknown so lit pixels go unchecked
  task automatic send_pixel(input logic [coord_w-1:0] hc, input logic [coord_w-1:0] vc,
                            input int vis);
    logic [31:0]        c;
    logic [3*rgb_w-1:0] want;
    logic               lit;
    @(negedge sysclk);
    if (exp_q.size() == 3) begin
      want = exp_q.pop_front();
      if (care_q.pop_front()) begin
        compare_channel("r", r, want[2*rgb_w +: rgb_w]);
        compare_channel("g", g, want[rgb_w +: rgb_w]);
        compare_channel("b", b, want[0 +: rgb_w]);
      end
    end
    random_bits(3 * rgb_w, c);
    hcnt        = hc;
    vcnt        = vc;
    rin         = c[2*rgb_w +: rgb_w];
    gin         = c[rgb_w +: rgb_w];
    bin         = c[0 +: rgb_w];
    uart_rx     = rx_level;
    uart_tx     = tx_level;
    wifi_enable = wifi_level;
    cycle_no++;
    lit = icon_lit(hc, vc, wifi_level);
    if (lit && vis == 1) begin
      want = wifi_level ? {chan_min, chan_max, chan_min} : {chan_max, chan_min, chan_min};
    end else begin
      want = c[3*rgb_w-1:0];
    end
    exp_q.push_back(want);
    care_q.push_back(!(lit && vis == 2));
  endtask

  // Flush the pipeline with pixels far from the icon
  task automatic drain();
    repeat (3) send_pixel(idle_pos, idle_pos, 0);
  endtask

  // Window plus a one pixel border around it
  task automatic scan_window(input int vis);
    for (int y = -1; y <= icon_size; y++) begin
      for (int x = -1; x <= icon_size; x++) begin
        send_pixel(coord_w'(int'(icon_x_first) + x), coord_w'(int'(win_top) + y), vis);
      end
    end
  endtask

  task automatic wait_reset_line(input logic level, input int limit);
    int n;
    n = 0;
    while (uart_reset_n !== level && n < limit) begin
      send_pixel(idle_pos, idle_pos, 0);
      n++;
    end
    if (uart_reset_n !== level) begin
      $display("Timeout: uart_reset_n did not reach %0b within %0d cycles", level, limit);
      stop_run();
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic test_pass_through();
    for (int i = 0; i < 12; i++) begin
      send_pixel(coord_w'(100 + 11 * i), coord_w'(40 + 17 * i), 0);
      if (i == 0) begin
        compare_bit("uart_reset_n", uart_reset_n, 1'b1);
      end
    end
    // Receive line low while the start-up hold runs
    rx_level = 1'b0;
    send_pixel(idle_pos, idle_pos, 0);
    rx_level = 1'b1;
    drain();
  endtask

  task automatic test_link_icon();
    wifi_level = 1'b1;
    rx_level   = 1'b0;
    scan_window(1);
    drain();
  endtask

  task automatic test_no_link_icon();
    wifi_level = 1'b0;
    scan_window(1);
    compare_bit("uart_reset_n", uart_reset_n, 1'b1);
    drain();
  endtask

  task automatic test_hold_expired();
    rx_level = 1'b1;
    wait_reset_line(1'b0, 100);
    scan_window(0);
    drain();
    wifi_level = 1'b1;
    wait_reset_line(1'b1, 4);
  endtask

  task automatic test_activity_restart();
    int pulse_at;
    int age;
    int vis;
    tx_level = 1'b0;
    send_pixel(idle_pos, idle_pos, 0);
    tx_level = 1'b1;
    pulse_at = cycle_no;
    // Lit pixels of link row 4, columns 4 to 11
    for (int i = 0; i < 80; i++) begin
      age = cycle_no + 1 + 3 - pulse_at;
      vis = (age <= 60) ? 1 : ((age >= 70) ? 0 : 2);
      send_pixel(coord_w'(int'(icon_x_first) + 4 + i % 8), coord_w'(int'(win_top) + 4), vis);
    end
    drain();
  endtask

  initial begin
    int n;
    hcnt        = '0;
    vcnt        = '0;
    end_count_v = frame_end;
    rin         = '0;
    gin         = '0;
    bin         = '0;
    uart_rx     = 1'b1;
    uart_tx     = 1'b1;
    wifi_enable = 1'b1;
    n = 0;
    while (rst_n !== 1'b1 && n < 20) begin
      @(posedge sysclk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      $display("Reset was never released");
      stop_run();
    end
    test_pass_through();
    test_link_icon();
    test_no_link_icon();
    test_hold_expired();
    test_activity_restart();
    $display("test passed");
    $finish;
  end

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period       = 100,
  parameter int reset_cycles = 8
) (
  output logic sysclk,
  output logic rst_n
);

  initial begin
    sysclk = 1'b0;
    forever #(period / 2) sysclk = ~sysclk;
  end

  // Release on a falling edge so the first active edge sees a clean level
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge sysclk);
    @(negedge sysclk);
    rst_n = 1'b1;
  end

endmodule

//--- source/status_icon_overlay.sv
`timescale 1ns/1ps

module status_icon_overlay
  import video_pkg::*, uart_pkg::*;
#(
  parameter logic [hold_cnt_w-1:0] hold_cycles = activity_hold_default
) (
  input  logic               sysclk,
  input  logic               rst_n,
  input  logic [coord_w-1:0] hcnt,
  input  logic [coord_w-1:0] vcnt,
  input  logic [coord_w-1:0] end_count_v,
  input  logic [rgb_w-1:0]   rin,
  input  logic [rgb_w-1:0]   gin,
  input  logic [rgb_w-1:0]   bin,
  input  logic               uart_rx,
  input  logic               uart_tx,
  input  logic               wifi_enable,
  output logic [rgb_w-1:0]   r,
  output logic [rgb_w-1:0]   g,
  output logic [rgb_w-1:0]   b,
  output logic               uart_reset_n
);

  logic                  icon_visible;

  // Stage 1 to stage 2
  logic                  s1_window;
  logic [icon_idx_w-1:0] s1_row;
  logic [icon_idx_w-1:0] s1_col;
  logic [rgb_w-1:0]      s1_r;
  logic [rgb_w-1:0]      s1_g;
  logic [rgb_w-1:0]      s1_b;

  // Stage 2 to stage 3
  logic                  s2_bit;
  logic                  s2_window;
  logic [rgb_w-1:0]      s2_r;
  logic [rgb_w-1:0]      s2_g;
  logic [rgb_w-1:0]      s2_b;

  uart_activity_monitor #(
    .hold_cycles (hold_cycles)
  ) activity0 (
    .sysclk       (sysclk),
    .rst_n        (rst_n),
    .uart_rx      (uart_rx),
    .uart_tx      (uart_tx),
    .wifi_enable  (wifi_enable),
    .icon_visible (icon_visible),
    .uart_reset_n (uart_reset_n)
  );

  icon_window_locator locate0 (
    .sysclk      (sysclk),
    .rst_n       (rst_n),
    .hcnt        (hcnt),
    .vcnt        (vcnt),
    .end_count_v (end_count_v),
    .rin         (rin),
    .gin         (gin),
    .bin         (bin),
    .in_window   (s1_window),
    .icon_row    (s1_row),
    .icon_col    (s1_col),
    .rout        (s1_r),
    .gout        (s1_g),
    .bout        (s1_b)
  );

  icon_bitmap_fetch fetch0 (
    .sysclk      (sysclk),
    .rst_n       (rst_n),
    .wifi_enable (wifi_enable),
    .in_window   (s1_window),
    .icon_row    (s1_row),
    .icon_col    (s1_col),
    .rin         (s1_r),
    .gin         (s1_g),
    .bin         (s1_b),
    .icon_bit    (s2_bit),
    .window_out  (s2_window),
    .rout        (s2_r),
    .gout        (s2_g),
    .bout        (s2_b)
  );

  icon_overlay_mixer mix0 (
    .sysclk       (sysclk),
    .rst_n        (rst_n),
    .wifi_enable  (wifi_enable),
    .icon_visible (icon_visible),
    .icon_bit     (s2_bit),
    .in_window    (s2_window),
    .rin          (s2_r),
    .gin          (s2_g),
    .bin          (s2_b),
    .r            (r),
    .g            (g),
    .b            (b)
  );

endmodule

//--- source/icon_overlay_mixer.sv
`timescale 1ns/1ps

module icon_overlay_mixer
  import video_pkg::*;
(
  input  logic             sysclk,
  input  logic             rst_n,
  input  logic             wifi_enable,
  input  logic             icon_visible,
  input  logic             icon_bit,
  input  logic             in_window,
  input  logic [rgb_w-1:0] rin,
  input  logic [rgb_w-1:0] gin,
  input  logic [rgb_w-1:0] bin,
  output logic [rgb_w-1:0] r,
  output logic [rgb_w-1:0] g,
  output logic [rgb_w-1:0] b
);

  logic paint;

  // Icon pixel lit, inside the window, while the hold is running
  assign paint = in_window && icon_visible && icon_bit;

  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      r <= chan_min;
      g <= chan_min;
      b <= chan_min;
    end else if (paint && wifi_enable) begin
      // Link icon in green
      r <= chan_min;
      g <= chan_max;
      b <= chan_min;
    end else if (paint) begin
      // No-link icon in red
      r <= chan_max;
      g <= chan_min;
      b <= chan_min;
    end else begin
      r <= rin;
      g <= gin;
      b <= bin;
    end
  end

endmodule

//--- source/icon_bitmap_fetch.sv
`timescale 1ns/1ps

module icon_bitmap_fetch
  import video_pkg::*;
(
  input  logic                  sysclk,
  input  logic                  rst_n,
  input  logic                  wifi_enable,
  input  logic                  in_window,
  input  logic [icon_idx_w-1:0] icon_row,
  input  logic [icon_idx_w-1:0] icon_col,
  input  logic [rgb_w-1:0]      rin,
  input  logic [rgb_w-1:0]      gin,
  input  logic [rgb_w-1:0]      bin,
  output logic                  icon_bit,
  output logic                  window_out,
  output logic [rgb_w-1:0]      rout,
  output logic [rgb_w-1:0]      gout,
  output logic [rgb_w-1:0]      bout
);

  // Column 0 sits in the most significant bit of each row
  localparam logic [icon_idx_w-1:0] last_col = icon_idx_w'(icon_size - 1);

  // ------------------------------
  // Bitmaps, row 0 at the top
  // ------------------------------

  // Signal arcs, shown while the module is enabled
  localparam logic [icon_size-1:0] link_icon [icon_size] = '{
    16'b0000000000000000,
    16'b0000000000000000,
    16'b0000000000000000,
    16'b0000000000000000,
    16'b0000111111110000,
    16'b0000000000000000,
    16'b0000011111100000,
    16'b0000000000000000,
    16'b0000001111000000,
    16'b0000000000000000,
    16'b0000000110000000,
    16'b0000000110000000,
    16'b0000000000000000,
    16'b0000000000000000,
    16'b0000000000000000,
    16'b0000000000000000
  };

  // Crossed-out arcs in a ring
  localparam logic [icon_size-1:0] no_link_icon [icon_size] = '{
    16'b0000011111100000,
    16'b0000100000010000,
    16'b0011000000001100,
    16'b0010000000000100,
    16'b0100111111111110,
    16'b1000000000110010,
    16'b1000011111100001,
    16'b1000000110000001,
    16'b1000001111000001,
    16'b1000011000000001,
    16'b1000110000000001,
    16'b0101100110000010,
    16'b0011000000000100,
    16'b0011000000001100,
    16'b0000110000110000,
    16'b0000001111000000
  };

  logic [icon_size-1:0] sel_row;

  assign sel_row = wifi_enable ? link_icon[icon_row] : no_link_icon[icon_row];

  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      window_out <= 1'b0;
    end else begin
      window_out <= in_window;
    end
  end

  always_ff @(posedge sysclk) begin
    icon_bit <= sel_row[last_col - icon_col];
    rout     <= rin;
    gout     <= gin;
    bout     <= bin;
  end

endmodule

//--- source/icon_window_locator.sv
`timescale 1ns/1ps

module icon_window_locator
  import video_pkg::*;
(
  input  logic                  sysclk,
  input  logic                  rst_n,
  input  logic [coord_w-1:0]    hcnt,
  input  logic [coord_w-1:0]    vcnt,
  input  logic [coord_w-1:0]    end_count_v,
  input  logic [rgb_w-1:0]      rin,
  input  logic [rgb_w-1:0]      gin,
  input  logic [rgb_w-1:0]      bin,
  output logic                  in_window,
  output logic [icon_idx_w-1:0] icon_row,
  output logic [icon_idx_w-1:0] icon_col,
  output logic [rgb_w-1:0]      rout,
  output logic [rgb_w-1:0]      gout,
  output logic [rgb_w-1:0]      bout
);

  logic [coord_w-1:0] y_top;
  logic [coord_w-1:0] dx;
  logic [coord_w-1:0] dy;
  logic               in_x;
  logic               in_y;

  // Window top follows the frame height of the current video mode
  assign y_top = end_count_v - icon_y_lead;

  // Offsets from the window corner
  assign dx = hcnt - icon_x_first;
  assign dy = vcnt - y_top;

  assign in_x = (hcnt >= icon_x_first) && (dx < coord_w'(icon_size));
  assign in_y = (vcnt >= y_top) && (dy < coord_w'(icon_size));

  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      in_window <= 1'b0;
    end else begin
      in_window <= in_x && in_y;
    end
  end

  // Offsets only matter inside the window
  always_ff @(posedge sysclk) begin
    icon_row <= dy[icon_idx_w-1:0];
    icon_col <= dx[icon_idx_w-1:0];
    rout     <= rin;
    gout     <= gin;
    bout     <= bin;
  end

endmodule

//--- source/uart_activity_monitor.sv
`timescale 1ns/1ps

module uart_activity_monitor
  import uart_pkg::*;
#(
  parameter logic [hold_cnt_w-1:0] hold_cycles = activity_hold_default
) (
  input  logic sysclk,
  input  logic rst_n,
  input  logic uart_rx,
  input  logic uart_tx,
  input  logic wifi_enable,
  output logic icon_visible,
  output logic uart_reset_n
);

  logic [hold_cnt_w-1:0] hold_cnt;
  logic                  link_seen;
  logic                  rx_low;
  logic                  tx_low;
  logic                  hold_running;

  assign rx_low       = (uart_rx == uart_line_low);
  assign tx_low       = (uart_tx == uart_line_low);
  assign hold_running = (hold_cnt != '0);

  // ------------------------------
  // Hold counter and link detect
  // ------------------------------

  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      hold_cnt  <= hold_cycles;
      link_seen <= 1'b0;
    end else begin
      // Before a link is seen the counter only runs down once
      if (link_seen && (rx_low || tx_low)) begin
        hold_cnt <= hold_cycles;
      end else if (hold_running) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
      // First receive edge inside the start-up window arms the monitor
      if (!link_seen && hold_running && rx_low) begin
        link_seen <= 1'b1;
      end
    end
  end

  assign icon_visible = hold_running;

  // Module held in reset while disabled and quiet
  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      uart_reset_n <= 1'b1;
    end else begin
      uart_reset_n <= wifi_enable || hold_running;
    end
  end

endmodule

//--- source/uart_pkg.sv
package uart_pkg;

  // ------------------------------
  // Activity monitor timing
  // ------------------------------

  // Hold counter width
  localparam int hold_cnt_w = 23;

  // Icon stays on for about 0.15 s at 28 MHz after the last traffic
  localparam logic [hold_cnt_w-1:0] activity_hold_default = 23'd4194303;

  // Serial lines idle high, any low level counts as traffic
  localparam logic uart_line_low = 1'b0;

endpackage

//--- source/video_pkg.sv
package video_pkg;

  // ------------------------------
  // Pixel stream
  // ------------------------------

  // Horizontal and vertical counters from the video timing generator
  localparam int coord_w = 9;

  // One color channel, three channels per pixel
  localparam int rgb_w = 3;

  localparam logic [rgb_w-1:0] chan_max = {rgb_w{1'b1}};
  localparam logic [rgb_w-1:0] chan_min = {rgb_w{1'b0}};

  // ------------------------------
  // Status icon geometry
  // ------------------------------

  // Square icon, side in pixels
  localparam int icon_size = 16;

  // Row and column index inside the icon
  localparam int icon_idx_w = 4;

  // Leftmost column of the icon window, covers 249 to 264
  localparam logic [coord_w-1:0] icon_x_first = 9'd249;

  // Top line of the window, counted back from the last line of the frame
  // Window spans this line and the following 15
  localparam logic [coord_w-1:0] icon_y_lead = 9'd21;

endpackage
